// File: Makefile
# Verilator simulation of the GPS tracking channel.
TOP = gps_channel_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qF "** PASS **" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall -f files.f --top-module $(TOP)
	verilator --lint-only -Wall logic/gps_channel_pkg.sv logic/wiped_sample_if.sv \
		logic/carrier_mixer.sv logic/ca_code_gen.sv logic/prompt_correlator.sv \
		logic/gps_channel.sv --top-module gps_channel

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
logic/gps_channel_pkg.sv
logic/wiped_sample_if.sv
logic/carrier_mixer.sv
logic/ca_code_gen.sv
logic/prompt_correlator.sv
logic/gps_channel.sv
verification/tb_clock.sv
verification/gps_channel_tb.sv

// File: logic/ca_code_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ca_code_gen
   import gps_channel_pkg::*;
(
   input  wire                      clk,
   input  wire                      reset_i,
   input  wire                      init_i,
   input  wire [PRN_WIDTH-1:0]      prn_i,
   input  wire [CODE_ACC_WIDTH-1:0] code_dphi_i,
   input  wire                      sample_valid_i,
   wiped_sample_if.code             wiped
);

   logic [PRN_WIDTH-1:0]      prn_q;
   logic [CODE_ACC_WIDTH-1:0] dphi_q;
   logic [CODE_ACC_WIDTH-1:0] code_phase;
   logic [CODE_ACC_WIDTH:0]   code_sum;
   logic [10:1]               g1;
   logic [10:1]               g2;
   logic [4:0]                tap_idx;
   logic [7:0]                taps;
   logic [3:0]                tap_a;
   logic [3:0]                tap_b;
   logic                      g1_fb;
   logic                      g2_fb;
   logic                      code_bit;
   logic                      accept;
   logic                      s1_chip;

   assign accept = sample_valid_i && !init_i;

   ////////////////////
   // Phase selector
   ////////////////////

   // PRN 1 sits at entry 0.
   assign tap_idx = 5'(prn_q - 6'd1);
   assign taps    = G2_TAPS[tap_idx];
   assign tap_a   = taps[7:4];
   assign tap_b   = taps[3:0];

   assign code_bit = g1[10] ^ g2[tap_a] ^ g2[tap_b];

   // Feedback polynomials of the two shift registers.
   assign g1_fb = g1[3] ^ g1[10];
   assign g2_fb = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];

   // The carry out of the code NCO is the chip clock.
   assign code_sum = {1'b0, code_phase} + {1'b0, dphi_q};

   ////////////////////
   // Code NCO and LFSRs
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset_i) begin
         prn_q      <= 6'd1;
         dphi_q     <= '0;
         code_phase <= '0;
         g1         <= '1;
         g2         <= '1;
      end else if (init_i) begin
         prn_q      <= prn_i;
         dphi_q     <= code_dphi_i;
         code_phase <= '0;
         g1         <= '1;
         g2         <= '1;
      end else if (accept) begin
         code_phase <= code_sum[CODE_ACC_WIDTH-1:0];
         if (code_sum[CODE_ACC_WIDTH]) begin
            g1 <= {g1[9:1], g1_fb};
            g2 <= {g2[9:1], g2_fb};
         end
      end
   end

   // Chip in force before this sample moves the NCO.
   always_ff @(posedge clk) begin
      if (accept) begin
         s1_chip <= code_bit;
      end
   end

   // Second stage lines the chip up with the mixer output.
   always_ff @(posedge clk) begin
      wiped.chip <= s1_chip;
   end

   a_g1_nonzero: assert property (
      @(posedge clk) disable iff (reset_i)
      g1 != '0
   );

   a_prn_range: assert property (
      @(posedge clk) disable iff (reset_i)
      init_i |-> (prn_i >= 6'd1 && prn_i <= 6'd32)
   );

endmodule

`default_nettype wire

// File: logic/carrier_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module carrier_mixer
   import gps_channel_pkg::*;
(
   input  wire                     clk,
   input  wire                     reset_i,
   input  wire                     init_i,
   input  wire [DOPPLER_WIDTH-1:0] doppler_i,
   input  wire                     sample_valid_i,
   input  wire sample_t            sample_i,
   wiped_sample_if.mixer           wiped
);

   logic [DOPPLER_WIDTH-1:0]         doppler_q;
   logic [CARRIER_ACC_WIDTH-1:0]     phase;
   logic [CARRIER_ACC_WIDTH-1:0]     phase_inc;
   logic [CARRIER_INDEX_WIDTH-1:0]   phase_idx;
   logic                             accept;
   logic                             s1_valid;
   sample_t                          s1_sample;
   logic signed [CARRIER_WIDTH-1:0]  s1_cos;
   logic signed [CARRIER_WIDTH-1:0]  s1_sin;

   // A strobe that lands on init is dropped.
   assign accept = sample_valid_i && !init_i;

   assign phase_idx = phase[CARRIER_ACC_WIDTH-1 -: CARRIER_INDEX_WIDTH];

   // IF step plus the sign-extended Doppler offset.
   assign phase_inc = CARRIER_IF_INC +
                      {{(CARRIER_ACC_WIDTH-DOPPLER_WIDTH){doppler_q[DOPPLER_WIDTH-1]}},
                       doppler_q};

   ////////////////////
   // Carrier NCO
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset_i) begin
         doppler_q <= '0;
         phase     <= '0;
         s1_valid  <= 1'b0;
      end else if (init_i) begin
         doppler_q <= doppler_i;
         phase     <= '0;
         s1_valid  <= 1'b0;
      end else begin
         s1_valid <= accept;
         if (accept) begin
            phase <= phase + phase_inc;
         end
      end
   end

   // Capture the sample with the carrier values at its phase.
   always_ff @(posedge clk) begin
      if (accept) begin
         s1_sample <= sample_i;
         s1_cos    <= COS_TABLE[phase_idx];
         s1_sin    <= SIN_TABLE[phase_idx];
      end
   end

   ////////////////////
   // Carrier wipe-off
   ////////////////////

   // An init cancels the sample still held in the first stage.
   always_ff @(posedge clk) begin
      if (reset_i) begin
         wiped.valid <= 1'b0;
      end else begin
         wiped.valid <= s1_valid && !init_i;
      end
   end

   // Q takes the negated sine product.
   always_ff @(posedge clk) begin
      if (s1_valid) begin
         wiped.i <= mixed_t'(s1_sample) * mixed_t'(s1_cos);
         wiped.q <= -(mixed_t'(s1_sample) * mixed_t'(s1_sin));
      end
   end

   // The cancel path keeps a restarted channel clean.
   a_no_valid_after_init: assert property (
      @(posedge clk) disable iff (reset_i)
      init_i |=> !wiped.valid
   );

endmodule

`default_nettype wire

// File: logic/gps_channel.sv
`timescale 1ns/1ps
`default_nettype none

module gps_channel
   import gps_channel_pkg::*;
#(
   parameter int ACC_LEN = 16
) (
   input  wire                      clk,
   input  wire                      reset_i,
   input  wire                      init_i,
   input  wire [PRN_WIDTH-1:0]      prn_i,
   input  wire [DOPPLER_WIDTH-1:0]  doppler_i,
   input  wire [CODE_ACC_WIDTH-1:0] code_dphi_i,
   input  wire                      sample_valid_i,
   input  wire sample_t             sample_i,
   output logic                     acc_valid_o,
   output acc_t                     i_prompt_o,
   output acc_t                     q_prompt_o
);

   // Mixer and code generator meet at the correlator on this bus.
   wiped_sample_if wiped_bus ();

   ////////////////////
   // Carrier side
   ////////////////////

   carrier_mixer u_carrier_mixer (
      .clk            (clk),
      .reset_i        (reset_i),
      .init_i         (init_i),
      .doppler_i      (doppler_i),
      .sample_valid_i (sample_valid_i),
      .sample_i       (sample_i),
      .wiped          (wiped_bus.mixer)
   );

   ////////////////////
   // Code side
   ////////////////////

   ca_code_gen u_ca_code_gen (
      .clk            (clk),
      .reset_i        (reset_i),
      .init_i         (init_i),
      .prn_i          (prn_i),
      .code_dphi_i    (code_dphi_i),
      .sample_valid_i (sample_valid_i),
      .wiped          (wiped_bus.code)
   );

   prompt_correlator #(
      .ACC_LEN (ACC_LEN)
   ) u_prompt_correlator (
      .clk         (clk),
      .reset_i     (reset_i),
      .init_i      (init_i),
      .wiped       (wiped_bus.correlator),
      .acc_valid_o (acc_valid_o),
      .i_prompt_o  (i_prompt_o),
      .q_prompt_o  (q_prompt_o)
   );

endmodule

`default_nettype wire

// File: logic/gps_channel_pkg.sv
`default_nettype none

package gps_channel_pkg;

   ////////////////////
   // Widths
   ////////////////////

   localparam int INPUT_WIDTH         = 3;
   localparam int PRN_WIDTH           = 6;
   localparam int DOPPLER_WIDTH       = 12;
   localparam int CARRIER_ACC_WIDTH   = 16;
   localparam int CARRIER_INDEX_WIDTH = 3;
   localparam int CARRIER_WIDTH       = 3;
   localparam int MIXED_WIDTH         = 6;
   localparam int CODE_ACC_WIDTH      = 16;
   localparam int ACC_WIDTH           = 16;

   // One sixteenth of a carrier cycle per sample.
   localparam logic [CARRIER_ACC_WIDTH-1:0] CARRIER_IF_INC = 16'd4096;

   typedef logic signed [INPUT_WIDTH-1:0] sample_t;
   typedef logic signed [MIXED_WIDTH-1:0] mixed_t;
   typedef logic signed [ACC_WIDTH-1:0]   acc_t;

   ////////////////////
   // Carrier tables
   ////////////////////

   // Coarse cosine and sine, eight phases per cycle.
   localparam logic signed [CARRIER_WIDTH-1:0] COS_TABLE [0:7] =
      '{3'sd2, 3'sd1, 3'sd0, -3'sd1, -3'sd2, -3'sd1, 3'sd0, 3'sd1};
   localparam logic signed [CARRIER_WIDTH-1:0] SIN_TABLE [0:7] =
      '{3'sd0, 3'sd1, 3'sd2, 3'sd1, 3'sd0, -3'sd1, -3'sd2, -3'sd1};

   ////////////////////
   // G2 phase selector
   ////////////////////

   // Entry n is PRN n+1; upper nibble and lower nibble are the G2 stages.
   localparam logic [7:0] G2_TAPS [0:31] = '{
      8'h26, 8'h37, 8'h48, 8'h59, 8'h19, 8'h2A, 8'h18, 8'h29,
      8'h3A, 8'h23, 8'h34, 8'h56, 8'h67, 8'h78, 8'h89, 8'h9A,
      8'h14, 8'h25, 8'h36, 8'h47, 8'h58, 8'h69, 8'h13, 8'h46,
      8'h57, 8'h68, 8'h79, 8'h8A, 8'h16, 8'h27, 8'h38, 8'h49
   };

endpackage

`default_nettype wire

// File: logic/prompt_correlator.sv
`timescale 1ns/1ps
`default_nettype none

module prompt_correlator
   import gps_channel_pkg::*;
#(
   parameter int ACC_LEN = 16
) (
   input  wire                clk,
   input  wire                reset_i,
   input  wire                init_i,
   wiped_sample_if.correlator wiped,
   output logic               acc_valid_o,
   output acc_t               i_prompt_o,
   output acc_t               q_prompt_o
);

   localparam int CNT_WIDTH = (ACC_LEN > 1) ? $clog2(ACC_LEN) : 1;

   logic [CNT_WIDTH-1:0] count;
   logic                 first;
   logic                 last;
   logic                 take;
   acc_t                 term_i;
   acc_t                 term_q;
   acc_t                 sum_i;
   acc_t                 sum_q;
   acc_t                 next_i;
   acc_t                 next_q;

   // Init wins over a sample arriving in the same cycle.
   assign take  = wiped.valid && !init_i;
   assign first = (count == '0);
   assign last  = (count == CNT_WIDTH'(ACC_LEN - 1));

   ////////////////////
   // Code wipe-off
   ////////////////////

   // Chip 1 adds, chip 0 subtracts.
   assign term_i = wiped.chip ? acc_t'(wiped.i) : -acc_t'(wiped.i);
   assign term_q = wiped.chip ? acc_t'(wiped.q) : -acc_t'(wiped.q);

   // First sample of a period starts a fresh sum.
   assign next_i = first ? term_i : sum_i + term_i;
   assign next_q = first ? term_q : sum_q + term_q;

   ////////////////////
   // Accumulate
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset_i) begin
         count       <= '0;
         sum_i       <= '0;
         sum_q       <= '0;
         i_prompt_o  <= '0;
         q_prompt_o  <= '0;
         acc_valid_o <= 1'b0;
      end else begin
         acc_valid_o <= 1'b0;
         if (init_i) begin
            count <= '0;
         end else if (take) begin
            sum_i <= next_i;
            sum_q <= next_q;
            if (last) begin
               count       <= '0;
               i_prompt_o  <= next_i;
               q_prompt_o  <= next_q;
               acc_valid_o <= 1'b1;
            end else begin
               count <= count + 1'b1;
            end
         end
      end
   end

   a_count_range: assert property (
      @(posedge clk) disable iff (reset_i)
      int'(count) < ACC_LEN
   );

endmodule

`default_nettype wire

// File: logic/wiped_sample_if.sv
`timescale 1ns/1ps
`default_nettype none

// One carrier-wiped sample with the prompt chip that belongs to it.
interface wiped_sample_if
   import gps_channel_pkg::*;
();

   logic   valid;
   mixed_t i;
   mixed_t q;
   logic   chip;

   modport mixer (output valid, output i, output q);

   modport code (output chip);

   modport correlator (input valid, input i, input q, input chip);

endinterface

`default_nettype wire

// File: verification/gps_channel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gps_channel_tb
   import gps_channel_pkg::*;
();

   localparam int ACC_LEN       = 16;
   localparam int PULSE_TIMEOUT = 200;

   logic                         clk;
   logic                         reset_i;
   logic                         init_i;
   logic [PRN_WIDTH-1:0]         prn_i;
   logic [DOPPLER_WIDTH-1:0]     doppler_i;
   logic [CODE_ACC_WIDTH-1:0]    code_dphi_i;
   logic                         sample_valid_i;
   sample_t                      sample_i;
   logic                         acc_valid_o;
   acc_t                         i_prompt_o;
   acc_t                         q_prompt_o;

   // Reference model state, updated on every accepted strobe.
   logic [31:0]                  lcg_state = 32'd85380;
   int                           edge_count = 0;
   logic [PRN_WIDTH-1:0]         model_prn;
   logic [DOPPLER_WIDTH-1:0]     model_doppler;
   logic [CODE_ACC_WIDTH-1:0]    model_dphi;
   logic [CARRIER_ACC_WIDTH-1:0] model_phase;
   logic [CODE_ACC_WIDTH-1:0]    model_code_phase;
   logic [10:1]                  model_g1;
   logic [10:1]                  model_g2;
   int                           model_count;
   int                           model_sum_i;
   int                           model_sum_q;
   acc_t                         held_sum_i;
   acc_t                         held_sum_q;
   int                           due_q[$];
   acc_t                         exp_i_q[$];
   acc_t                         exp_q_q[$];

   tb_clock clock_gen (.clk_o(clk));

   gps_channel #(
      .ACC_LEN (ACC_LEN)
   ) dut (
      .clk            (clk),
      .reset_i        (reset_i),
      .init_i         (init_i),
      .prn_i          (prn_i),
      .doppler_i      (doppler_i),
      .code_dphi_i    (code_dphi_i),
      .sample_valid_i (sample_valid_i),
      .sample_i       (sample_i),
      .acc_valid_o    (acc_valid_o),
      .i_prompt_o     (i_prompt_o),
      .q_prompt_o     (q_prompt_o)
   );

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic check_sum(input string name, input acc_t got, input acc_t expected);
      assert (got === expected)
         else fail_now($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, expected));
   endtask

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic sample_t random_sample();
      logic [31:0] r;
      r = next_random();
      return sample_t'(r[18:16]);
   endfunction

   ////////////////////
   // Reference model
   ////////////////////

   function automatic int cos_val(input logic [2:0] idx);
      case (idx)
         3'd0: return 2;
         3'd1: return 1;
         3'd2: return 0;
         3'd3: return -1;
         3'd4: return -2;
         3'd5: return -1;
         3'd6: return 0;
         3'd7: return 1;
      endcase
   endfunction

   function automatic int sin_val(input logic [2:0] idx);
      case (idx)
         3'd0: return 0;
         3'd1: return 1;
         3'd2: return 2;
         3'd3: return 1;
         3'd4: return 0;
         3'd5: return -1;
         3'd6: return -2;
         3'd7: return -1;
      endcase
   endfunction

   // Only the PRNs that the stimulus uses.
   task automatic g2_stages(input logic [PRN_WIDTH-1:0] prn, output logic [3:0] a,
                            output logic [3:0] b);
      a = 4'd1;
      b = 4'd1;
      case (prn)
         6'd1: begin
            a = 4'd2;
            b = 4'd6;
         end
         6'd7: begin
            a = 4'd1;
            b = 4'd8;
         end
         default: fail_now("the model has no G2 taps for this PRN");
      endcase
   endtask

   task automatic restart_model();
      model_phase      = '0;
      model_code_phase = '0;
      model_g1         = '1;
      model_g2         = '1;
      model_count      = 0;
   endtask

   task automatic advance_model(input sample_t s);
      logic [2:0]  idx;
      logic [3:0]  tap_a;
      logic [3:0]  tap_b;
      logic        chip;
      logic [16:0] code_sum;
      int          mix_i;
      int          mix_q;
      idx   = model_phase[15:13];
      mix_i = int'(s) * cos_val(idx);
      mix_q = -(int'(s) * sin_val(idx));
      g2_stages(model_prn, tap_a, tap_b);
      chip = model_g1[10] ^ model_g2[tap_a] ^ model_g2[tap_b];
      if (!chip) begin
         mix_i = -mix_i;
         mix_q = -mix_q;
      end
      if (model_count == 0) begin
         model_sum_i = mix_i;
         model_sum_q = mix_q;
      end else begin
         model_sum_i = model_sum_i + mix_i;
         model_sum_q = model_sum_q + mix_q;
      end
      model_count = model_count + 1;
      // The result shows two edges after the strobe is taken.
      if (model_count == ACC_LEN) begin
         due_q.push_back(edge_count + 2);
         exp_i_q.push_back(acc_t'(model_sum_i));
         exp_q_q.push_back(acc_t'(model_sum_q));
         model_count = 0;
      end
      model_phase = model_phase + 16'(4096 + int'($signed(model_doppler)));
      code_sum = {1'b0, model_code_phase} + {1'b0, model_dphi};
      model_code_phase = code_sum[15:0];
      if (code_sum[16]) begin
         model_g1 = {model_g1[9:1], model_g1[3] ^ model_g1[10]};
         model_g2 = {model_g2[9:1], model_g2[2] ^ model_g2[3] ^ model_g2[6] ^
                     model_g2[8] ^ model_g2[9] ^ model_g2[10]};
      end
   endtask

   // Inputs read here are the values the DUT samples on this edge.
   always @(posedge clk) begin
      edge_count = edge_count + 1;
      if (reset_i) begin
         model_prn     = 6'd1;
         model_doppler = '0;
         model_dphi    = '0;
         held_sum_i    = '0;
         held_sum_q    = '0;
         restart_model();
         due_q.delete();
         exp_i_q.delete();
         exp_q_q.delete();
      end else if (init_i) begin
         model_prn     = prn_i;
         model_doppler = doppler_i;
         model_dphi    = code_dphi_i;
         restart_model();
         // Periods that would end at or after the init are lost in flight.
         while (due_q.size() != 0 && due_q[$] >= edge_count) begin
            void'(due_q.pop_back());
            void'(exp_i_q.pop_back());
            void'(exp_q_q.pop_back());
         end
      end else if (sample_valid_i) begin
         advance_model(sample_i);
      end
   end

   ////////////////////
   // Checks
   ////////////////////

   // Outputs are defined only from the first reset edge on.
   always @(negedge clk) begin
      if (edge_count > 0) begin
         if (acc_valid_o === 1'b1) begin
            assert (due_q.size() != 0 && due_q[0] == edge_count)
               else fail_now("acc_valid_o pulsed although no accumulation period ended");
            check_sum("i_prompt_o", i_prompt_o, exp_i_q[0]);
            check_sum("q_prompt_o", q_prompt_o, exp_q_q[0]);
            held_sum_i = exp_i_q[0];
            held_sum_q = exp_q_q[0];
            void'(due_q.pop_front());
            void'(exp_i_q.pop_front());
            void'(exp_q_q.pop_front());
         end else begin
            assert (acc_valid_o === 1'b0) else fail_now("acc_valid_o is unknown");
            assert (due_q.size() == 0 || due_q[0] > edge_count)
               else fail_now("acc_valid_o missed the end of an accumulation period");
            // Sums stay on the outputs until the next pulse.
            check_sum("i_prompt_o", i_prompt_o, held_sum_i);
            check_sum("q_prompt_o", q_prompt_o, held_sum_q);
         end
      end
   end

   a_pulse_one_cycle: assert property (
      @(posedge clk) disable iff (reset_i)
      acc_valid_o |=> !acc_valid_o
   ) else fail_now("acc_valid_o stayed high for more than one cycle");

   a_quiet_after_init: assert property (
      @(posedge clk) disable iff (reset_i)
      init_i |=> !acc_valid_o
   ) else fail_now("acc_valid_o pulsed in the cycle after init");

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic send_sample(input sample_t value, input int gap);
      sample_valid_i <= 1'b1;
      sample_i       <= value;
      @(posedge clk);
      sample_valid_i <= 1'b0;
      repeat (gap) @(posedge clk);
   endtask

   task automatic stream_samples(input int count, input logic zeros);
      logic [31:0] r;
      sample_t     value;
      for (int n = 0; n < count; n++) begin
         r     = next_random();
         value = zeros ? sample_t'(0) : sample_t'(r[18:16]);
         send_sample(value, int'(r[21:20]));
      end
   endtask

   task automatic start_channel(input logic [PRN_WIDTH-1:0] prn,
                                input logic [DOPPLER_WIDTH-1:0] doppler,
                                input logic [CODE_ACC_WIDTH-1:0] dphi,
                                input logic with_strobe);
      init_i         <= 1'b1;
      prn_i          <= prn;
      doppler_i      <= doppler;
      code_dphi_i    <= dphi;
      sample_valid_i <= with_strobe;
      sample_i       <= random_sample();
      @(posedge clk);
      init_i         <= 1'b0;
      sample_valid_i <= 1'b0;
   endtask

   task automatic wait_for_pulse();
      int waited;
      waited = 0;
      do begin
         @(posedge clk);
         waited = waited + 1;
         if (waited > PULSE_TIMEOUT) begin
            fail_now("timed out waiting for acc_valid_o");
         end
      end while (acc_valid_o !== 1'b1);
   endtask

   task automatic drain_pulses();
      @(posedge clk);
      while (due_q.size() != 0) begin
         wait_for_pulse();
      end
   endtask

   initial begin
      logic [31:0] r;
      reset_i        = 1'b1;
      init_i         = 1'b0;
      prn_i          = 6'd1;
      doppler_i      = '0;
      code_dphi_i    = '0;
      sample_valid_i = 1'b0;
      sample_i       = '0;
      repeat (2) @(posedge clk);
      reset_i <= 1'b0;

      // Idle channel.
      repeat (20) @(posedge clk);

      // Zero input gives zero sums.
      r = next_random();
      start_channel(6'd1, r[27:16], 16'd8192, 1'b0);
      stream_samples(2 * ACC_LEN, 1'b1);
      drain_pulses();

      // PRN 1, random samples and gaps, several periods.
      r = next_random();
      start_channel(6'd1, r[27:16], 16'd8192, 1'b0);
      stream_samples(4 * ACC_LEN, 1'b0);
      drain_pulses();

      // Restart mid-period with two samples still in flight and a strobe on init.
      stream_samples(ACC_LEN / 2, 1'b0);
      send_sample(random_sample(), 0);
      send_sample(random_sample(), 0);
      r = next_random();
      start_channel(6'd7, r[27:16], 16'd12288, 1'b1);
      stream_samples(3 * ACC_LEN, 1'b0);
      drain_pulses();

      // Restart while the closing sample of a period is still in flight.
      stream_samples(ACC_LEN - 1, 1'b0);
      send_sample(random_sample(), 0);
      send_sample(random_sample(), 0);
      r = next_random();
      start_channel(6'd7, r[27:16], 16'd12288, 1'b0);
      stream_samples(ACC_LEN, 1'b0);
      drain_pulses();

      repeat (5) @(posedge clk);
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running 100 ns clock.
module tb_clock (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

endmodule

`default_nettype wire
